//--- compile.f
+incdir+source
source/minibyte_isa_pkg.sv
source/minibyte_ctrl_pkg.sv
source/minibyte_ctrl_if.sv
source/minibyte_cu.sv
source/minibyte_datapath.sv
source/minibyte_top.sv
test/tb_clock_gen.sv
test/tb_minibyte.sv

//--- run.sh
#!/bin/sh
# Build the accumulator processor testbench with Verilator and run it.
# Exits non-zero if the build, the run or the result check fails.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=sim_minibyte
LOG=sim.log

verilator --binary --timing -f compile.f --top-module tb_minibyte \
    --Mdir "$BUILD_DIR" -o "$SIM_EXE"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
exit 1

//--- test/minibyte_testdata.hex
// Memory image at 000-0FF: program bytes from 000, direct-mode data from 080
// Check table at 100: instruction count, program length, expected acc per instruction
@000
01 3C 03 F0 05 40 07 0F  // LDA, ADD overflow, SUB borrow, AND (immediate)
09 A0 0B FF 00 0D FF     // OR, XOR, NOP, two undefined opcodes
02 80 04 81 06 82        // LDA, ADD overflow, SUB borrow (direct)
08 83 0A 84 0C 85        // AND, OR, XOR (direct)
00 04 86 06 87           // NOP, ADD overflow, SUB borrow (direct)
@080
9A 7B 3C F3 05 66 C8 E0
// Separator: check table follows
@100
12 20
3C 2C EC 0C AC 53        // immediate results
53 53 53                 // NOP and undefined opcodes keep acc
9A 15 D9 D1 D5 B3        // direct results
B3 7B 9B                 // NOP, ADD, SUB

//--- test/tb_minibyte.sv
//--------------------------------------------------------------------------
// Testbench for the accumulator processor: memory model loaded from the
// test data file, per-instruction checks of acc and mem_addr, watchdog
// and closing summary
//--------------------------------------------------------------------------
`include "minibyte_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_minibyte;

    localparam int CLK_PERIOD_NS = 10;
    // Check table follows the memory image
    localparam int TABLE_BASE    = `MB_MEM_DEPTH;
    localparam int FILE_WORDS    = 2 * `MB_MEM_DEPTH;

    wire                   clk_in;
    wire                   rst_in;
    wire [`MB_ADDR_W-1:0]  mem_addr;
    wire [`MB_DATA_W-1:0]  mem_rdata;
    wire [`MB_DATA_W-1:0]  acc;

    logic [`MB_DATA_W-1:0] filedata [0:FILE_WORDS-1];
    logic [`MB_DATA_W-1:0] mem [0:`MB_MEM_DEPTH-1];

    int num_instr = 0;
    int prog_len  = 0;
    int errors    = 0;
    int checks    = 0;
    bit loaded    = 1'b0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) clkgen0 (
        .clk_in (clk_in),
        .rst_in (rst_in)
    );

    minibyte_top dut0 (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .acc       (acc)
    );

    // Combinational read that is valid in the same cycle
    assign mem_rdata = mem[mem_addr];

    function automatic logic [`MB_DATA_W-1:0] fill_byte(int addr);
        return 8'(addr) ^ 8'(addr >> 8) ^ 8'hc3;
    endfunction

    // Opcodes 1 to 12 carry an operand byte
    function automatic int instr_bytes(logic [`MB_DATA_W-1:0] op);
        return (op >= 8'd1 && op <= 8'd12) ? 2 : 1;
    endfunction

    // Even opcodes 2 to 12 fetch their data through M
    function automatic bit is_direct(logic [`MB_DATA_W-1:0] op);
        return (op >= 8'd2 && op <= 8'd12 && !op[0]);
    endfunction

    // Fetch 3 and decode 1 plus 2 or 4 execute cycles
    function automatic int instr_cycles(logic [`MB_DATA_W-1:0] op);
        if (instr_bytes(op) == 1) begin
            return 4;
        end
        return is_direct(op) ? 8 : 6;
    endfunction

    task automatic check_value(input string name, input logic [`MB_DATA_W-1:0] expected,
                               input logic [`MB_DATA_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    initial begin : load_testdata
        int i;
        for (i = 0; i < FILE_WORDS; i++) begin
            filedata[i] = fill_byte(i);
        end
        $readmemh("test/minibyte_testdata.hex", filedata);
        for (i = 0; i < `MB_MEM_DEPTH; i++) begin
            mem[i] = filedata[i];
        end
        num_instr = int'(filedata[TABLE_BASE]);
        prog_len  = int'(filedata[TABLE_BASE + 1]);
        loaded    = 1'b1;
    end

    //----------------------------------------------------------------------
    // Program walk, one instruction at a time
    //----------------------------------------------------------------------
    initial begin : run_program
        logic [`MB_ADDR_W-1:0] pc;
        logic [`MB_DATA_W-1:0] op;
        logic [`MB_DATA_W-1:0] operand;
        int n;
        int k;

        wait (loaded);
        if (num_instr == 0) begin
            errors++;
            $display("Test data file lists no instructions to run");
        end

        // Still in the RESET phase here
        @(posedge rst_in);
        @(negedge clk_in);
        check_value("acc", 8'h00, acc);
        check_value("mem_addr", 8'h00, mem_addr);

        // First fetch cycle
        @(posedge clk_in);
        @(negedge clk_in);
        pc = '0;
        for (n = 0; n < num_instr; n++) begin
            op      = mem[pc];
            operand = mem[pc + 8'd1];
            check_value("mem_addr", pc, mem_addr);
            for (k = 1; k < instr_cycles(op); k++) begin
                @(posedge clk_in);
                @(negedge clk_in);
                // EXEC2 and EXEC3 address the data byte
                if (is_direct(op) && k >= 6) begin
                    check_value("mem_addr", operand, mem_addr);
                end
            end
            @(posedge clk_in);
            @(negedge clk_in);
            pc = pc + 8'(instr_bytes(op));
            check_value("acc", filedata[TABLE_BASE + 2 + n], acc);
        end
        check_value("mem_addr", 8'(prog_len), mem_addr);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Longest instruction is 8 cycles
    initial begin : watchdog
        int limit_ns;
        wait (loaded);
        limit_ns = (num_instr * 8 + 20) * CLK_PERIOD_NS;
        #(limit_ns);
        $display("Timeout: the program did not finish within %0d ns", limit_ns);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
//--------------------------------------------------------------------------
// Testbench clock and reset generator
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_in,
    output logic rst_in
);

    initial begin
        clk_in = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_in = ~clk_in;
        end
    end

    // Release just after a rising edge
    initial begin
        rst_in = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #1;
        rst_in = 1'b1;
    end

endmodule

`default_nettype wire

//--- source/minibyte_top.sv
//--------------------------------------------------------------------------
// Processor top level: control unit and datapath joined by the control
// interface, memory bus and accumulator as plain ports
//--------------------------------------------------------------------------
`include "minibyte_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module minibyte_top (
    input  wire                     clk_in,
    input  wire                     rst_in,
    output logic [`MB_ADDR_W-1:0]   mem_addr,
    input  wire  [`MB_DATA_W-1:0]   mem_rdata,
    output logic [`MB_DATA_W-1:0]   acc
);

    // Strobes and IR between control unit and datapath
    minibyte_ctrl_if ctrl0 ();

    minibyte_cu cu0 (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .ctrl   (ctrl0.cu_mp)
    );

    minibyte_datapath dp0 (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .ctrl      (ctrl0.dp_mp),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .acc       (acc)
    );

endmodule

`default_nettype wire

//--- source/minibyte_datapath.sv
//--------------------------------------------------------------------------
// Datapath: registers A, M, PC and IR, the ALU and the memory address
// multiplexer
//--------------------------------------------------------------------------
`include "minibyte_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module minibyte_datapath (
    input  wire                     clk_in,
    input  wire                     rst_in,
    minibyte_ctrl_if.dp_mp          ctrl,
    output logic [`MB_ADDR_W-1:0]   mem_addr,
    input  wire  [`MB_DATA_W-1:0]   mem_rdata,
    output logic [`MB_DATA_W-1:0]   acc
);
    import minibyte_isa_pkg::*;
    import minibyte_ctrl_pkg::*;

    logic [`MB_DATA_W-1:0] a_q;
    logic [`MB_ADDR_W-1:0] m_q;
    logic [`MB_ADDR_W-1:0] pc_q;
    logic [`MB_DATA_W-1:0] alu_res;

    //----------------------------------------------------------------------
    // ALU
    //----------------------------------------------------------------------
    // A is the first operand and memory data the second
    // Results wrap at the data width
    always_comb begin
        case (ctrl.alu_op)
            ALU_PASS: alu_res = mem_rdata;
            ALU_ADD:  alu_res = a_q + mem_rdata;
            ALU_SUB:  alu_res = a_q - mem_rdata;
            ALU_AND:  alu_res = a_q & mem_rdata;
            ALU_OR:   alu_res = a_q | mem_rdata;
            ALU_XOR:  alu_res = a_q ^ mem_rdata;
            default:  alu_res = '0;
        endcase
    end

    //----------------------------------------------------------------------
    // Registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            a_q     <= '0;
            m_q     <= '0;
            pc_q    <= '0;
            ctrl.ir <= OP_NOP;
        end else begin
            if (ctrl.set_a) begin
                a_q <= alu_res;
            end

            // Operand address straight from memory
            if (ctrl.set_m) begin
                m_q <= mem_rdata;
            end

            if (ctrl.set_ir) begin
                ctrl.ir <= opcode_e'(mem_rdata);
            end

            // Wraps at the top of memory
            if (ctrl.inc_pc) begin
                pc_q <= pc_q + 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // Address multiplexer and outputs
    //----------------------------------------------------------------------
    assign mem_addr = (ctrl.addr_sel == ADDR_M) ? m_q : pc_q;
    assign acc      = a_q;

endmodule

`default_nettype wire

//--- source/minibyte_cu.sv
//--------------------------------------------------------------------------
// Control unit: phase sequencer and decode of the control strobes from
// the phase and the opcode in IR
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module minibyte_cu (
    input  wire             clk_in,
    input  wire             rst_in,
    minibyte_ctrl_if.cu_mp  ctrl
);
    import minibyte_isa_pkg::*;
    import minibyte_ctrl_pkg::*;

    cu_phase_e phase_q;
    cu_phase_e phase_d;

    // Opcode decode
    alu_op_e   ir_alu;
    logic      ir_direct;
    logic      ir_exec;

    assign ir_alu    = op_alu(ctrl.ir);
    assign ir_direct = op_is_direct(ctrl.ir);
    // NOP and unknown opcodes have no ALU operation and skip execute
    assign ir_exec   = (ir_alu != ALU_ZERO);

    //----------------------------------------------------------------------
    // Phase register
    //----------------------------------------------------------------------
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            phase_q <= PH_RESET;
        end else begin
            phase_q <= phase_d;
        end
    end

    //----------------------------------------------------------------------
    // Next phase
    //----------------------------------------------------------------------
    always_comb begin
        case (phase_q)
            PH_RESET:  phase_d = PH_FETCH0;
            PH_FETCH0: phase_d = PH_FETCH1;
            PH_FETCH1: phase_d = PH_FETCH2;
            PH_FETCH2: phase_d = PH_DECODE;
            PH_DECODE: phase_d = ir_exec ? PH_EXEC0 : PH_FETCH0;
            PH_EXEC0:  phase_d = PH_EXEC1;
            // Immediate ops finish here
            PH_EXEC1:  phase_d = ir_direct ? PH_EXEC2 : PH_FETCH0;
            PH_EXEC2:  phase_d = PH_EXEC3;
            PH_EXEC3:  phase_d = PH_FETCH0;
            default:   phase_d = PH_FETCH0;
        endcase
    end

    //----------------------------------------------------------------------
    // Strobe decode
    //----------------------------------------------------------------------
    always_comb begin
        ctrl.set_a    = 1'b0;
        ctrl.set_m    = 1'b0;
        ctrl.set_ir   = 1'b0;
        ctrl.inc_pc   = 1'b0;
        ctrl.addr_sel = ADDR_PC;
        ctrl.alu_op   = ALU_ZERO;

        case (phase_q)
            // Opcode at PC onto the bus
            PH_FETCH0: begin
                ctrl.alu_op = ALU_PASS;
            end

            PH_FETCH1: begin
                ctrl.alu_op = ALU_PASS;
                ctrl.set_ir = 1'b1;
            end

            // Step PC to the operand byte
            PH_FETCH2: begin
                ctrl.alu_op = ALU_PASS;
                ctrl.inc_pc = 1'b1;
            end

            // Operand byte at PC holds the value or its address
            PH_EXEC0: begin
                ctrl.alu_op = ir_direct ? ALU_PASS : ir_alu;
            end

            PH_EXEC1: begin
                ctrl.alu_op = ir_direct ? ALU_PASS : ir_alu;
                if (ir_direct) begin
                    ctrl.set_m = 1'b1;
                end else begin
                    ctrl.set_a  = 1'b1;
                    ctrl.inc_pc = 1'b1;
                end
            end

            // Direct ops read the data byte through M
            PH_EXEC2: begin
                ctrl.addr_sel = ADDR_M;
                ctrl.alu_op   = ir_alu;
            end

            PH_EXEC3: begin
                ctrl.addr_sel = ADDR_M;
                ctrl.alu_op   = ir_alu;
                ctrl.set_a    = 1'b1;
                ctrl.inc_pc   = 1'b1;
            end

            // Reset and decode leave everything idle
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/minibyte_ctrl_if.sv
//--------------------------------------------------------------------------
// Control strobes from the control unit to the datapath, and the
// instruction register back
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface minibyte_ctrl_if;
    import minibyte_isa_pkg::*;
    import minibyte_ctrl_pkg::*;

    // Register load and PC increment strobes
    logic      set_a;
    logic      set_m;
    logic      set_ir;
    logic      inc_pc;

    addr_sel_e addr_sel;
    alu_op_e   alu_op;

    // Current instruction
    opcode_e   ir;

    modport cu_mp (
        output set_a, set_m, set_ir, inc_pc, addr_sel, alu_op,
        input  ir
    );

    modport dp_mp (
        input  set_a, set_m, set_ir, inc_pc, addr_sel, alu_op,
        output ir
    );

endinterface

`default_nettype wire

//--- source/minibyte_ctrl_pkg.sv
//--------------------------------------------------------------------------
// Control unit types: phase sequence and address source select
//--------------------------------------------------------------------------
`default_nettype none

package minibyte_ctrl_pkg;

    // One phase per clock cycle
    //   fetch takes three cycles, decode one
    //   immediate ops use EXEC0..EXEC1, direct ops EXEC0..EXEC3
    typedef enum logic [3:0] {
        PH_RESET  = 4'd0,
        PH_FETCH0 = 4'd1,
        PH_FETCH1 = 4'd2,
        PH_FETCH2 = 4'd3,
        PH_DECODE = 4'd4,
        PH_EXEC0  = 4'd5,
        PH_EXEC1  = 4'd6,
        PH_EXEC2  = 4'd7,
        PH_EXEC3  = 4'd8
    } cu_phase_e;

    // Source of the memory address
    typedef enum logic {
        ADDR_PC = 1'b0,
        ADDR_M  = 1'b1
    } addr_sel_e;

endpackage

`default_nettype wire

//--- source/minibyte_isa_pkg.sv
//--------------------------------------------------------------------------
// Instruction set: opcode and ALU operation types, plus the decode
// functions for ALU operation and addressing mode
//--------------------------------------------------------------------------
`include "minibyte_defines.svh"
`default_nettype none

package minibyte_isa_pkg;

    // Opcode values as stored in program memory
    typedef enum logic [`MB_DATA_W-1:0] {
        OP_NOP     = 0,
        OP_LDA_IMM = 1,
        OP_LDA_DIR = 2,
        OP_ADD_IMM = 3,
        OP_ADD_DIR = 4,
        OP_SUB_IMM = 5,
        OP_SUB_DIR = 6,
        OP_AND_IMM = 7,
        OP_AND_DIR = 8,
        OP_OR_IMM  = 9,
        OP_OR_DIR  = 10,
        OP_XOR_IMM = 11,
        OP_XOR_DIR = 12
    } opcode_e;

    // Second operand of every ALU operation is the memory data
    typedef enum logic [2:0] {
        ALU_ZERO = 3'd0,
        ALU_PASS = 3'd1,
        ALU_ADD  = 3'd2,
        ALU_SUB  = 3'd3,
        ALU_AND  = 3'd4,
        ALU_OR   = 3'd5,
        ALU_XOR  = 3'd6
    } alu_op_e;

    // NOP and undefined opcodes give ALU_ZERO
    function automatic alu_op_e op_alu(opcode_e op);
        case (op)
            OP_LDA_IMM, OP_LDA_DIR: return ALU_PASS;
            OP_ADD_IMM, OP_ADD_DIR: return ALU_ADD;
            OP_SUB_IMM, OP_SUB_DIR: return ALU_SUB;
            OP_AND_IMM, OP_AND_DIR: return ALU_AND;
            OP_OR_IMM,  OP_OR_DIR:  return ALU_OR;
            OP_XOR_IMM, OP_XOR_DIR: return ALU_XOR;
            default:                return ALU_ZERO;
        endcase
    endfunction

    // Direct mode opcodes are the even ones from 2 to 12
    function automatic logic op_is_direct(opcode_e op);
        case (op)
            OP_LDA_DIR, OP_ADD_DIR, OP_SUB_DIR,
            OP_AND_DIR, OP_OR_DIR, OP_XOR_DIR: return 1'b1;
            default:                           return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/minibyte_defines.svh
//--------------------------------------------------------------------------
// Widths and memory size shared by the accumulator processor and its
// testbench
//--------------------------------------------------------------------------
`default_nettype none
`ifndef MINIBYTE_DEFINES_SVH
`define MINIBYTE_DEFINES_SVH

// Data bus, A and IR
`define MB_DATA_W    8
// Memory addresses, PC and M
`define MB_ADDR_W    8
`define MB_MEM_DEPTH 256

`endif
`default_nettype wire
